/* common/alu_pkg.sv */
// Shared definitions for the integer execution unit
// Widths, multiply sequencing constants, operation and FSM encodings

package alu_pkg;

    ////////////////////////////////////////////////////////////////////
    // Widths
    ////////////////////////////////////////////////////////////////////

    // Operand and result width
    localparam int XLEN      = 32;
    // One shift-add step per multiplier bit
    localparam int MUL_STEPS = 32;
    // Enough to count MUL_STEPS iterations
    localparam int CNT_W     = 5;

    ////////////////////////////////////////////////////////////////////
    // Encodings
    ////////////////////////////////////////////////////////////////////

    // Operation selector
    typedef enum logic [3:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLL,
        OP_SRL,
        OP_SRA,
        OP_SLT,
        OP_SLTU,
        OP_MUL,
        OP_MULHU
    } alu_op_e;

    // Multiply sequencer states
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_RUN,
        ST_FINISH
    } mul_state_e;

endpackage

/* alu/adder.sv */
// Ripple-carry adder with carry-in
// Per-bit full-adder chain; no carry-out, widen operands to get one

`timescale 1ns/10ps

module adder #(
    parameter int WIDTH = 32
) (
    input  logic             cin,
    input  logic [WIDTH-1:0] a,
    input  logic [WIDTH-1:0] b,
    output logic [WIDTH-1:0] sum
);

    // Carry into each bit position
    logic [WIDTH-1:0] carry;

    assign carry[0] = cin;

    genvar i;
    generate
        for (i = 0; i < WIDTH; i = i + 1) begin : g_bit
            // Sum bit of the full adder
            assign sum[i] = a[i] ^ b[i] ^ carry[i];

            // Carry out to the next stage, top bit has none
            if (i < WIDTH - 1) begin : g_carry
                assign carry[i+1] = (a[i] & b[i]) |
                                    (a[i] & carry[i]) |
                                    (b[i] & carry[i]);
            end
        end
    endgenerate

endmodule

/* alu/alu_comb.sv */
// Single-cycle ALU datapath
// Add, subtract and signed compare share one ripple-carry adder

`timescale 1ns/10ps

module alu_comb import alu_pkg::*; (
    input  alu_op_e          op,
    input  logic [XLEN-1:0]  a,
    input  logic [XLEN-1:0]  b,
    output logic [XLEN-1:0]  result
);

    logic            sub_mode;
    logic [XLEN-1:0] b_in;
    logic [XLEN-1:0] sum;
    logic [4:0]      shamt;
    logic            slt_bit;
    logic            sltu_bit;

    ////////////////////////////////////////////////////////////////////
    // Adder operand setup
    ////////////////////////////////////////////////////////////////////

    // Subtract as a + ~b + 1
    assign sub_mode = (op == OP_SUB) || (op == OP_SLT);
    assign b_in     = sub_mode ? ~b : b;

    adder #(
        .WIDTH (XLEN)
    ) i_adder (
        .cin (sub_mode),
        .a   (a),
        .b   (b_in),
        .sum (sum)
    );

    ////////////////////////////////////////////////////////////////////
    // Compares and shift amount
    ////////////////////////////////////////////////////////////////////

    // Signs differ: a is less exactly when a is negative
    // Signs equal: no overflow, so the difference sign decides
    assign slt_bit = (a[XLEN-1] ^ b[XLEN-1]) ? a[XLEN-1] : sum[XLEN-1];

    // Plain magnitude compare
    assign sltu_bit = (a < b);

    // Only the low 5 bits of b count
    assign shamt = b[4:0];

    ////////////////////////////////////////////////////////////////////
    // Result mux
    ////////////////////////////////////////////////////////////////////

    always_comb begin
        case (op)
            OP_ADD,
            OP_SUB:  result = sum;
            OP_AND:  result = a & b;
            OP_OR:   result = a | b;
            OP_XOR:  result = a ^ b;
            OP_SLL:  result = a << shamt;
            OP_SRL:  result = a >> shamt;
            OP_SRA:  result = $signed(a) >>> shamt;
            OP_SLT:  result = {{(XLEN-1){1'b0}}, slt_bit};
            OP_SLTU: result = {{(XLEN-1){1'b0}}, sltu_bit};
            // Multiply results come from the iterative path
            default: result = '0;
        endcase
    end

endmodule

/* alu/mul_ctrl.sv */
// Multiply sequencer FSM
// Steers load, 32 shift-add steps and the finish cycle

`timescale 1ns/10ps

module mul_ctrl import alu_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    input  logic mul_start,
    input  logic last,
    output logic load,
    output logic step,
    output logic finish,
    output logic cnt_clr,
    output logic cnt_en,
    output logic busy
);

    mul_state_e state;
    mul_state_e state_nxt;

    // State register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // Next state
    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: begin
                if (mul_start) begin
                    state_nxt = ST_RUN;
                end
            end
            // Leave on the step that sees the last count
            ST_RUN: begin
                if (last) begin
                    state_nxt = ST_FINISH;
                end
            end
            ST_FINISH: state_nxt = ST_IDLE;
            default:   state_nxt = ST_IDLE;
        endcase
    end

    // Outputs decoded from state
    assign load    = (state == ST_IDLE) && mul_start;
    assign cnt_clr = load;
    assign step    = (state == ST_RUN);
    assign cnt_en  = step;
    assign finish  = (state == ST_FINISH);
    assign busy    = (state != ST_IDLE);

endmodule

/* alu/mul_counter.sv */
// Multiply step counter
// Counts shift-add steps and flags the final one

`timescale 1ns/10ps

module mul_counter import alu_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    input  logic clr,
    input  logic en,
    output logic last
);

    logic [CNT_W-1:0] cnt;

    // Clear wins over count
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (clr) begin
            cnt <= '0;
        end else if (en) begin
            cnt <= cnt + 1'b1;
        end
    end

    // High during the last step
    assign last = (cnt == CNT_W'(MUL_STEPS - 1));

endmodule

/* alu/mul_datapath.sv */
// Shift-add multiply datapath
// Multiplicand, 33-bit accumulator and low product half, one bit per step

`timescale 1ns/10ps

module mul_datapath import alu_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            load,
    input  logic            step,
    input  logic [XLEN-1:0] a,
    input  logic [XLEN-1:0] b,
    output logic [XLEN-1:0] prod_lo,
    output logic [XLEN-1:0] prod_hi
);

    logic [XLEN-1:0] mcand;
    // Upper accumulator, one extra bit holds the add carry
    logic [XLEN:0]   acc;
    // Low half, starts as the multiplier
    logic [XLEN-1:0] lo;
    logic [XLEN:0]   addend;
    logic [XLEN:0]   sum;

    // Multiplicand captured once per multiply
    always_ff @(posedge clk) begin
        if (load) begin
            mcand <= a;
        end
    end

    // Add multiplicand only when the current multiplier bit is set
    assign addend = lo[0] ? {1'b0, mcand} : '0;

    adder #(
        .WIDTH (XLEN + 1)
    ) i_adder (
        .cin (1'b0),
        .a   (acc),
        .b   (addend),
        .sum (sum)
    );

    // Product register, shifted right by one each step
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc <= '0;
            lo  <= '0;
        end else if (load) begin
            acc <= '0;
            lo  <= b;
        end else if (step) begin
            acc <= {1'b0, sum[XLEN:1]};
            lo  <= {sum[0], lo[XLEN-1:1]};
        end
    end

    assign prod_lo = lo;
    assign prod_hi = acc[XLEN-1:0];

endmodule

/* rtl/alu_top.sv */
// Integer execution unit top level
// Single-cycle ops and iterative multiply behind a start, busy and done strobe

`timescale 1ns/10ps

module alu_top import alu_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            start,
    input  alu_op_e         op,
    input  logic [XLEN-1:0] a,
    input  logic [XLEN-1:0] b,
    output logic [XLEN-1:0] result,
    output logic            done,
    output logic            busy
);

    logic            accept;
    alu_op_e         op_q;
    logic [XLEN-1:0] a_q;
    logic [XLEN-1:0] b_q;
    logic            comb_pend;
    logic            mul_start;
    logic [XLEN-1:0] comb_result;
    logic            load;
    logic            step;
    logic            finish;
    logic            cnt_clr;
    logic            cnt_en;
    logic            last;
    logic            mul_busy;
    logic [XLEN-1:0] prod_lo;
    logic [XLEN-1:0] prod_hi;

    ////////////////////////////////////////////////////////////////////
    // Start acceptance and operand capture
    ////////////////////////////////////////////////////////////////////

    // Busy also covers the cycle between capture and load
    assign busy   = mul_busy | mul_start;
    assign accept = start && !busy;

    always_ff @(posedge clk) begin
        if (accept) begin
            op_q <= op;
            a_q  <= a;
            b_q  <= b;
        end
    end

    // Route the accepted op to the single-cycle or multiply path
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            comb_pend <= 1'b0;
            mul_start <= 1'b0;
        end else begin
            comb_pend <= accept && !(op inside {OP_MUL, OP_MULHU});
            mul_start <= accept && (op inside {OP_MUL, OP_MULHU});
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Execution paths
    ////////////////////////////////////////////////////////////////////

    alu_comb i_alu_comb (
        .op     (op_q),
        .a      (a_q),
        .b      (b_q),
        .result (comb_result)
    );

    mul_ctrl i_mul_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .mul_start (mul_start),
        .last      (last),
        .load      (load),
        .step      (step),
        .finish    (finish),
        .cnt_clr   (cnt_clr),
        .cnt_en    (cnt_en),
        .busy      (mul_busy)
    );

    mul_counter i_mul_counter (
        .clk   (clk),
        .rst_n (rst_n),
        .clr   (cnt_clr),
        .en    (cnt_en),
        .last  (last)
    );

    mul_datapath i_mul_datapath (
        .clk     (clk),
        .rst_n   (rst_n),
        .load    (load),
        .step    (step),
        .a       (a_q),
        .b       (b_q),
        .prod_lo (prod_lo),
        .prod_hi (prod_hi)
    );

    ////////////////////////////////////////////////////////////////////
    // Result register and done pulse
    ////////////////////////////////////////////////////////////////////

    // Result holds until the next done
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result <= '0;
            done   <= 1'b0;
        end else begin
            done <= 1'b0;
            if (comb_pend) begin
                result <= comb_result;
                done   <= 1'b1;
            end else if (finish) begin
                // High word for MULHU, low word for MUL
                result <= (op_q == OP_MULHU) ? prod_hi : prod_lo;
                done   <= 1'b1;
            end
        end
    end

endmodule

/* tests/tb_clk_gen.sv */
// Testbench clock source
// Free-running clock that starts low

`timescale 1ns/10ps

module tb_clk_gen #(
    parameter int PERIOD = 40
) (
    output logic clk
);

    // Half period per toggle
    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD / 2) clk = ~clk;
        end
    end

endmodule

/* tests/tb_alu_top.sv */
// Testbench for the integer execution unit
// Directed tests against a reference model built from the operation rules

`timescale 1ns/10ps

module tb_alu_top import alu_pkg::*; ();

    logic            clk;
    logic            rst_n;
    logic            start;
    alu_op_e         op;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] result;
    logic            done;
    logic            busy;

    integer seed;
    int     checks;
    int     errors;
    int     timeouts;
    // Cycle limit for any single wait loop
    int     max_wait;

    tb_clk_gen i_clk_gen (
        .clk (clk)
    );

    alu_top i_alu_top (
        .clk    (clk),
        .rst_n  (rst_n),
        .start  (start),
        .op     (op),
        .a      (a),
        .b      (b),
        .result (result),
        .done   (done),
        .busy   (busy)
    );

    //////////////////////////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////////////////////////

    function automatic logic is_mul(input alu_op_e o);
        return (o == OP_MUL) || (o == OP_MULHU);
    endfunction

    // Load edge, one edge per step, finish edge
    function automatic int expected_latency(input alu_op_e o);
        return is_mul(o) ? MUL_STEPS + 2 : 1;
    endfunction

    function automatic logic [XLEN-1:0] ref_result(input alu_op_e o,
                                                   input logic [XLEN-1:0] x,
                                                   input logic [XLEN-1:0] y);
        logic [2*XLEN-1:0] prod;
        logic [4:0]        sh;
        logic [XLEN-1:0]   r;
        sh   = y[4:0];
        // Full unsigned product, 64 bits
        prod = {{XLEN{1'b0}}, x} * {{XLEN{1'b0}}, y};
        case (o)
            OP_ADD:  r = x + y;
            OP_SUB:  r = x - y;
            OP_AND:  r = x & y;
            OP_OR:   r = x | y;
            OP_XOR:  r = x ^ y;
            OP_SLL:  r = x << sh;
            OP_SRL:  r = x >> sh;
            OP_SRA: begin
                // Logical shift, then refill the vacated top bits with the sign
                r = x >> sh;
                if (x[XLEN-1]) begin
                    r = r | ~({XLEN{1'b1}} >> sh);
                end
            end
            OP_SLT:   r = {{(XLEN-1){1'b0}}, ($signed(x) < $signed(y))};
            OP_SLTU:  r = {{(XLEN-1){1'b0}}, (x < y)};
            OP_MUL:   r = prod[XLEN-1:0];
            OP_MULHU: r = prod[2*XLEN-1:XLEN];
            default:  r = '0;
        endcase
        return r;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Compare tasks
    //////////////////////////////////////////////////////////////////////

    task automatic check_result(input string name, input logic [XLEN-1:0] got,
                                input logic [XLEN-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_latency(input string name, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("MISMATCH at %0t: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Operation driver
    //////////////////////////////////////////////////////////////////////

    // Called on a falling edge; returns on the falling edge that sees done
    task automatic run_op(input alu_op_e op_in, input logic [XLEN-1:0] a_in,
                          input logic [XLEN-1:0] b_in);
        logic [XLEN-1:0] exp;
        int              cycles;
        exp   = ref_result(op_in, a_in, b_in);
        op    = op_in;
        a     = a_in;
        b     = b_in;
        start = 1'b1;
        @(negedge clk);
        start  = 1'b0;
        cycles = 0;
        while (!done && cycles < max_wait) begin
            // Busy only for multiply
            check_bit("busy", busy, is_mul(op_in));
            @(negedge clk);
            cycles++;
        end
        if (!done) begin
            timeouts++;
            $display("Timeout: no done within %0d cycles for %s at %0t",
                     max_wait, op_in.name(), $time);
        end else begin
            check_result($sformatf("result(%s)", op_in.name()), result, exp);
            check_latency("done latency", cycles, expected_latency(op_in));
            check_bit("busy", busy, 1'b0);
        end
    endtask

    task automatic run_random(input alu_op_e op_in, input int count);
        logic [XLEN-1:0] ra;
        logic [XLEN-1:0] rb;
        repeat (count) begin
            ra = $random(seed);
            rb = $random(seed);
            run_op(op_in, ra, rb);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////////////////////////

    task automatic test_reset();
        @(negedge clk);
        check_bit("done", done, 1'b0);
        check_bit("busy", busy, 1'b0);
        check_result("result", result, '0);
    endtask

    task automatic test_add_sub();
        // Carry across every bit, then wraparound
        run_op(OP_ADD, 32'hffff_ffff, 32'h0000_0001);
        run_op(OP_ADD, 32'h7fff_ffff, 32'h0000_0001);
        run_op(OP_ADD, 32'hffff_ffff, 32'hffff_ffff);
        run_op(OP_ADD, 32'h0000_0000, 32'h0000_0000);
        run_op(OP_SUB, 32'h0000_0000, 32'h0000_0001);
        run_op(OP_SUB, 32'h1234_5678, 32'h0000_0000);
        run_op(OP_SUB, 32'h8000_0000, 32'h0000_0001);
        run_random(OP_ADD, 8);
        run_random(OP_SUB, 8);
    endtask

    task automatic test_logic_cmp();
        alu_op_e ops [8];
        ops = '{OP_AND, OP_OR, OP_XOR, OP_SLL, OP_SRL, OP_SRA, OP_SLT, OP_SLTU};
        foreach (ops[i]) begin
            run_random(ops[i], 6);
        end
        // Upper bits of b ignored by shifts
        run_op(OP_SLL, 32'h8000_0001, 32'hffff_ffe3);
        run_op(OP_SRL, 32'h8000_0001, 32'h0000_0020);
        run_op(OP_SRA, 32'h8000_0000, 32'h0000_003f);
        run_op(OP_SRA, 32'h7fff_ff00, 32'h0000_0004);
        // Opposite signs
        run_op(OP_SLT,  32'h8000_0000, 32'h0000_0001);
        run_op(OP_SLTU, 32'h8000_0000, 32'h0000_0001);
        run_op(OP_SLT,  32'h0000_0001, 32'hffff_ffff);
        run_op(OP_SLTU, 32'h0000_0001, 32'hffff_ffff);
        run_op(OP_SLT,  32'h7fff_ffff, 32'h8000_0000);
        run_op(OP_SLTU, 32'h0000_0005, 32'h0000_0005);
    endtask

    task automatic test_mul();
        run_op(OP_MUL,   32'hffff_ffff, 32'hffff_ffff);
        run_op(OP_MULHU, 32'hffff_ffff, 32'hffff_ffff);
        run_op(OP_MUL,   32'h0000_0000, 32'hdead_beef);
        run_op(OP_MULHU, 32'h8000_0000, 32'h0000_0002);
        run_random(OP_MUL, 4);
        run_random(OP_MULHU, 4);
    endtask

    // Starts during a multiply are dropped, next op runs clean
    task automatic test_busy();
        logic [XLEN-1:0] a1;
        logic [XLEN-1:0] b1;
        logic [XLEN-1:0] exp;
        int              cycles;
        a1    = $random(seed);
        b1    = $random(seed);
        exp   = ref_result(OP_MULHU, a1, b1);
        op    = OP_MULHU;
        a     = a1;
        b     = b1;
        start = 1'b1;
        @(negedge clk);
        cycles = 0;
        while (!done && cycles < max_wait) begin
            check_bit("busy", busy, 1'b1);
            // Stray starts right away and mid-run
            if (cycles == 0 || cycles == 10) begin
                start = 1'b1;
                op    = (cycles == 0) ? OP_ADD : OP_MUL;
                a     = $random(seed);
                b     = $random(seed);
            end else begin
                start = 1'b0;
            end
            @(negedge clk);
            cycles++;
        end
        start = 1'b0;
        if (!done) begin
            timeouts++;
            $display("Timeout: multiply with stray starts never finished at %0t", $time);
        end else begin
            // One done only, and it belongs to the first op
            check_result("result(busy MULHU)", result, exp);
            check_latency("done latency", cycles, expected_latency(OP_MULHU));
            check_bit("busy", busy, 1'b0);
            run_random(OP_SUB, 1);
            repeat (3) begin
                @(negedge clk);
                check_bit("done", done, 1'b0);
                check_bit("busy", busy, 1'b0);
            end
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        seed     = 40;
        checks   = 0;
        errors   = 0;
        timeouts = 0;
        max_wait = 100;
        rst_n    = 1'b0;
        start    = 1'b0;
        op       = OP_ADD;
        a        = '0;
        b        = '0;
        repeat (16) @(negedge clk);
        rst_n = 1'b1;

        test_reset();
        test_add_sub();
        test_logic_cmp();
        test_mul();
        test_busy();

        $display("Checks %0d, mismatches %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* list.f */
common/alu_pkg.sv
alu/adder.sv
alu/alu_comb.sv
alu/mul_ctrl.sv
alu/mul_counter.sv
alu/mul_datapath.sv
rtl/alu_top.sv
tests/tb_clk_gen.sv
tests/tb_alu_top.sv

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator, run it, then search the log for the pass line
rm -rf obj_dir sim.log &&
verilator --binary --timing --top-module tb_alu_top -f list.f -o tb_alu_top \
    > build.log 2>&1 &&
./obj_dir/tb_alu_top > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "^TB PASSED$" sim.log && echo "Simulation passed" && exit 0 ||
{ echo "Simulation failed, see build.log and sim.log"; exit 1; }
